// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module slurm16_cpu_operand_fetch_tb -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Test failures found" $(LOG) || ! grep -q "All tests passed!" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== slurm16_cpu_decode.sv ====
`default_nettype none

module slurm16_cpu_decode (
	input  logic [slurm16_pkg::BITS - 1:0] instruction,
	output slurm16_pkg::reg_sel_t sel
);

	slurm16_pkg::instr_class_t ins_class;
	logic [slurm16_pkg::REGISTER_BITS - 1:0] dest;
	logic [slurm16_pkg::REGISTER_BITS - 1:0] src;
	logic [slurm16_pkg::REGISTER_BITS - 1:0] idx;
	logic [slurm16_pkg::REGISTER_BITS - 1:0] ext;

	// field slices shared by several classes
	assign ins_class = slurm16_pkg::class_from_ins(instruction);
	assign dest = slurm16_pkg::reg_dest_from_ins(instruction);
	assign src = slurm16_pkg::reg_src_from_ins(instruction);
	assign idx = slurm16_pkg::reg_idx_from_ins(instruction);
	assign ext = slurm16_pkg::reg_extended_from_ins(instruction);

	always_comb begin
		sel = '0;	// read r0 and write nothing unless a class says otherwise

		case (ins_class)
			slurm16_pkg::CLASS_NOP_RET: begin
				if (slurm16_pkg::is_iret(instruction))
					sel.reg_a = slurm16_pkg::INTERRUPT_LINK_REGISTER;	// iret wins over ret
				else if (slurm16_pkg::is_ret(instruction))
					sel.reg_a = slurm16_pkg::LINK_REGISTER;
			end
			slurm16_pkg::CLASS_ALU_REG_REG, slurm16_pkg::CLASS_COND_MOV: begin
				sel.reg_a = dest;
				sel.reg_b = src;
				sel.wr_sel = dest;
			end
			slurm16_pkg::CLASS_ALU_SINGLE_REG: begin
				sel.reg_b = src;	// single operand ops only touch flags here
			end
			slurm16_pkg::CLASS_ALU_REG_IMM: begin
				sel.reg_a = dest;
				sel.wr_sel = dest;
			end
			slurm16_pkg::CLASS_BRANCH: begin
				sel.reg_a = slurm16_pkg::reg_branch_ind_from_ins(instruction);	// indirect base
			end
			slurm16_pkg::CLASS_LOAD, slurm16_pkg::CLASS_PEEK: begin
				sel.reg_a = dest;
				sel.reg_b = idx;	// index register for the address
				sel.wr_sel = dest;
			end
			slurm16_pkg::CLASS_ALU_REG_EXREG: begin
				sel.reg_a = ext;
				sel.reg_b = src;
				sel.wr_sel = ext;
			end
			slurm16_pkg::CLASS_ALU_EXREG_REG: begin
				sel.reg_a = src;
				sel.reg_b = ext;
				sel.wr_sel = src;
			end
			slurm16_pkg::CLASS_LOAD_EX: begin
				sel.reg_a = ext;
				sel.reg_b = src;	// low register acts as the index
				sel.wr_sel = ext;
			end
			default: begin
				sel = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== slurm16_cpu_hazard.sv ====
`default_nettype none

module slurm16_cpu_hazard (
	input  logic CLK,
	input  logic reset,
	input  logic set_en,
	input  logic [slurm16_pkg::REGISTER_BITS - 1:0] set_sel,
	input  logic clr_en,
	input  logic [slurm16_pkg::REGISTER_BITS - 1:0] clr_sel,
	input  slurm16_pkg::reg_sel_t check,
	output logic conflict
);

	logic [slurm16_pkg::NUM_REGISTERS - 1:0] pending;	// one bit per register awaiting write-back
	logic a_pending;
	logic b_pending;
	logic a_clearing;
	logic b_clearing;

	// ####################
	// scoreboard update
	// ####################

	always_ff @(posedge CLK) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (clr_en)
				pending[clr_sel] <= 1'b0;
			if (set_en && (set_sel != '0))
				pending[set_sel] <= 1'b1;	// a new writer outranks a retiring one
		end
	end

	// ####################
	// conflict test
	// ####################

	assign a_pending = pending[check.reg_a];
	assign b_pending = pending[check.reg_b];

	// a write-back landing now is forwarded by the register file so it frees the register
	assign a_clearing = clr_en && (clr_sel == check.reg_a);
	assign b_clearing = clr_en && (clr_sel == check.reg_b);

	assign conflict = (a_pending && !a_clearing) || (b_pending && !b_clearing);

endmodule

`default_nettype wire

// ==== slurm16_cpu_operand_fetch.sv ====
`default_nettype none

module slurm16_cpu_operand_fetch (
	input  logic CLK,
	input  logic reset,
	input  logic instr_valid,
	input  logic [slurm16_pkg::BITS - 1:0] instruction,
	input  logic wb_valid,
	input  slurm16_pkg::writeback_t wb,
	output logic busy,
	output logic op_valid,
	output slurm16_pkg::operand_bundle_t operands
);

	logic [slurm16_pkg::BITS - 1:0] held_instruction;
	slurm16_pkg::reg_sel_t sel;	// selects of the instruction being considered
	logic conflict;
	logic issue;
	logic [slurm16_pkg::BITS - 1:0] rd_a;
	logic [slurm16_pkg::BITS - 1:0] rd_b;

	slurm16_cpu_decode decode_i (
		.instruction(held_instruction),
		.sel(sel)
	);

	// write-back lands here and in the scoreboard on the same edge
	slurm16_cpu_registers registers_i (
		.CLK(CLK),
		.reset(reset),
		.wr_en(wb_valid),
		.wr(wb),
		.rd_a_sel(sel.reg_a),
		.rd_b_sel(sel.reg_b),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	slurm16_cpu_hazard hazard_i (
		.CLK(CLK),
		.reset(reset),
		.set_en(issue),
		.set_sel(sel.wr_sel),
		.clr_en(wb_valid),
		.clr_sel(wb.sel),
		.check(sel),
		.conflict(conflict)
	);

	slurm16_cpu_pipeline_control pipeline_control_i (
		.CLK(CLK),
		.reset(reset),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.sel(sel),
		.conflict(conflict),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.held_instruction(held_instruction),
		.issue(issue),
		.busy(busy),
		.op_valid(op_valid),
		.operands(operands)
	);

endmodule

`default_nettype wire

// ==== slurm16_cpu_operand_fetch_assert.sv ====
`default_nettype none

module slurm16_cpu_operand_fetch_assert (
	input  logic CLK,
	input  logic reset,
	input  logic instr_valid,
	input  logic busy,
	input  logic op_valid
);

	// outputs settle low once reset has been seen
	reset_quiet: assert property (@(posedge CLK) reset |=> (!busy && !op_valid))
		else $error("busy or op_valid high right after reset");

	// a strobe during a hold is dropped by the control FSM
	no_strobe_while_busy: assert property (@(posedge CLK) disable iff (reset)
		busy |-> !instr_valid)
		else $error("instr_valid raised while busy");

	op_valid_one_cycle: assert property (@(posedge CLK) disable iff (reset)
		op_valid |=> !op_valid)
		else $error("op_valid lasted longer than one cycle");

	op_valid_not_busy: assert property (@(posedge CLK) disable iff (reset)
		!(op_valid && busy))
		else $error("op_valid and busy high together");

endmodule

bind slurm16_cpu_operand_fetch slurm16_cpu_operand_fetch_assert slurm16_cpu_operand_fetch_assert_i (
	.CLK(CLK),
	.reset(reset),
	.instr_valid(instr_valid),
	.busy(busy),
	.op_valid(op_valid)
);

`default_nettype wire

// ==== slurm16_cpu_operand_fetch_tb.sv ====
`default_nettype none

module slurm16_cpu_operand_fetch_tb;

	typedef enum logic [1:0] {
		row_instr,
		row_wb,
		row_instr_wb	// instruction plus a write-back to its register A in the same cycle
	} row_kind_t;

	logic CLK = 1'b0;
	logic reset;
	logic instr_valid;
	logic [15:0] instruction;
	logic wb_valid;
	slurm16_pkg::writeback_t wb;
	logic busy;
	logic op_valid;
	slurm16_pkg::operand_bundle_t operands;

	string row_name [$];
	row_kind_t row_kind [$];
	logic [15:0] row_word [$];
	logic [6:0] row_w [$];	// write-back target, or the expected write select of an instruction
	logic [6:0] row_a [$];
	logic [6:0] row_b [$];

	logic [15:0] shadow_regs [128];
	logic [127:0] shadow_pending;
	logic held;	// an instruction waits inside the DUT
	slurm16_pkg::reg_sel_t held_sel;
	slurm16_pkg::reg_sel_t exp_sel;
	logic is_instr;
	logic is_wb;
	logic issued;
	logic [6:0] wb_sel;
	logic [31:0] rng_state;
	int cycle_count = 0;

	slurm16_cpu_operand_fetch slurm16_cpu_operand_fetch_i (
		.CLK(CLK),
		.reset(reset),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.wb_valid(wb_valid),
		.wb(wb),
		.busy(busy),
		.op_valid(op_valid),
		.operands(operands)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= 20 * row_name.size() + 100)
			fail_run("Timeout: the table did not finish within the cycle limit");
	end

	// ####################
	// helpers
	// ####################

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			fail_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// independent copy of the decode table
	function automatic slurm16_pkg::reg_sel_t expected_selects(input logic [15:0] w);
		slurm16_pkg::reg_sel_t s;
		logic [6:0] d;
		logic [6:0] r;
		logic [6:0] x;
		logic [6:0] e;
		d = {3'b000, w[7:4]};
		r = {3'b000, w[3:0]};
		x = {3'b000, w[11:8]};
		e = w[10:4];
		s = '0;
		case (w[15:12])
			4'd0: s.reg_a = w[9] ? 7'd14 : (w[8] ? 7'd15 : 7'd0);
			4'd1, 4'd5: s = {d, r, d};
			4'd2: s.reg_b = r;
			4'd3: s = {d, 7'd0, d};
			4'd4: s.reg_a = d;
			4'd6, 4'd7: s = {d, x, d};
			4'd8, 4'd10: s = {e, r, e};
			4'd9: s = {r, e, r};
			default: s = '0;
		endcase
		return s;
	endfunction

	task automatic add_row(input string name, input row_kind_t kind, input logic [15:0] word,
		input logic [6:0] w, input logic [6:0] a, input logic [6:0] b);
		row_name.push_back(name);
		row_kind.push_back(kind);
		row_word.push_back(word);
		row_w.push_back(w);
		row_a.push_back(a);
		row_b.push_back(b);
	endtask

	task automatic build_table();
		add_row("nop", row_instr, 16'h0000, 7'd0, 7'd0, 7'd0);
		add_row("ret", row_instr, 16'h0100, 7'd0, 7'd15, 7'd0);
		add_row("iret", row_instr, 16'h0200, 7'd0, 7'd14, 7'd0);
		add_row("iret_over_ret", row_instr, 16'h0300, 7'd0, 7'd14, 7'd0);
		add_row("alu_reg_reg", row_instr, 16'h1023, 7'd2, 7'd2, 7'd3);
		add_row("alu_single", row_instr, 16'h2047, 7'd0, 7'd0, 7'd7);
		add_row("alu_imm", row_instr, 16'h3061, 7'd6, 7'd6, 7'd0);
		add_row("branch", row_instr, 16'h4080, 7'd0, 7'd8, 7'd0);
		add_row("cond_mov", row_instr, 16'h5019, 7'd1, 7'd1, 7'd9);
		add_row("load", row_instr, 16'h6B3C, 7'd3, 7'd3, 7'd11);
		add_row("peek", row_instr, 16'h7D4A, 7'd4, 7'd4, 7'd13);
		add_row("alu_reg_exreg", row_instr, 16'h8640, 7'd100, 7'd100, 7'd0);
		add_row("alu_exreg_reg", row_instr, 16'h9259, 7'd9, 7'd9, 7'd37);
		add_row("load_ex", row_instr, 16'hA7AE, 7'd122, 7'd122, 7'd14);
		add_row("undefined", row_instr, 16'hF123, 7'd0, 7'd0, 7'd0);
		// write-backs fill registers and retire the writers above
		add_row("wb_r15", row_wb, 16'h0000, 7'd15, 7'd0, 7'd0);
		add_row("wb_r100", row_wb, 16'h0000, 7'd100, 7'd0, 7'd0);
		add_row("wb_r7", row_wb, 16'h0000, 7'd7, 7'd0, 7'd0);
		add_row("wb_r0", row_wb, 16'h0000, 7'd0, 7'd0, 7'd0);
		add_row("wb_r6", row_wb, 16'h0000, 7'd6, 7'd0, 7'd0);
		add_row("wb_r3", row_wb, 16'h0000, 7'd3, 7'd0, 7'd0);
		add_row("wb_r4", row_wb, 16'h0000, 7'd4, 7'd0, 7'd0);
		add_row("read_ret", row_instr, 16'h0100, 7'd0, 7'd15, 7'd0);
		add_row("read_r100_r7", row_instr, 16'h8647, 7'd100, 7'd100, 7'd7);
		add_row("read_r0_r6", row_instr, 16'h5006, 7'd0, 7'd0, 7'd6);
		// stall and release around register 5
		add_row("write_r5", row_instr, 16'h1050, 7'd5, 7'd5, 7'd0);
		add_row("unrelated_r3_r4", row_instr, 16'h1034, 7'd3, 7'd3, 7'd4);
		add_row("stall_on_r5", row_instr, 16'h1085, 7'd8, 7'd8, 7'd5);
		add_row("wb_r7_in_stall", row_wb, 16'h0000, 7'd7, 7'd0, 7'd0);
		add_row("wb_r5_release", row_wb, 16'h0000, 7'd5, 7'd0, 7'd0);
		add_row("write_r10", row_instr, 16'h30A0, 7'd10, 7'd10, 7'd0);
		add_row("forward_r10", row_instr_wb, 16'h10A0, 7'd10, 7'd10, 7'd0);
		add_row("stall_r3_r8", row_instr, 16'h1038, 7'd3, 7'd3, 7'd8);
		add_row("wb_r3_partial", row_wb, 16'h0000, 7'd3, 7'd0, 7'd0);
		add_row("wb_r8_release", row_wb, 16'h0000, 7'd8, 7'd0, 7'd0);
		// r10 stays pending after the same-cycle set and clear above
		add_row("stall_on_r10", row_instr, 16'h200A, 7'd0, 7'd0, 7'd10);
		add_row("wb_r10_release", row_wb, 16'h0000, 7'd10, 7'd0, 7'd0);
	endtask

	// ####################
	// stimulus and checks
	// ####################

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instruction = '0;
		wb_valid = 1'b0;
		wb = '0;
		rng_state = 32'hd9c9_3dcc;
		held = 1'b0;
		held_sel = '0;
		shadow_pending = '0;
		for (int r = 0; r < 128; r++)
			shadow_regs[r] = '0;
		build_table();
		repeat (4) @(posedge CLK);
		#1 reset = 1'b0;
		check_value("reset busy", 32'(1'b0), 32'(busy));
		check_value("reset op_valid", 32'(1'b0), 32'(op_valid));

		for (int i = 0; i < row_name.size(); i++) begin
			exp_sel = {row_a[i], row_b[i], row_w[i]};
			is_instr = (row_kind[i] != row_wb);
			is_wb = (row_kind[i] != row_instr);
			wb_sel = (row_kind[i] == row_instr_wb) ? row_a[i] : row_w[i];
			if (is_instr) begin
				check_value({row_name[i], " table"}, 32'(expected_selects(row_word[i])),
					32'(exp_sel));
				if (held)
					fail_run("Table error: an instruction row comes while one is still held");
				held = 1'b1;
				held_sel = exp_sel;
			end

			instr_valid = is_instr;
			instruction = row_word[i];
			wb_valid = is_wb;
			if (is_wb) begin
				rng_state = xorshift(rng_state);
				wb = {wb_sel, rng_state[15:0]};
			end
			@(posedge CLK);
			#1;
			instr_valid = 1'b0;
			wb_valid = 1'b0;

			// the edge writes first, then the held instruction may issue
			if (is_wb && (wb_sel != 7'd0))
				shadow_regs[wb_sel] = wb.data;
			if (is_wb)
				shadow_pending[wb_sel] = 1'b0;
			issued = held && !shadow_pending[held_sel.reg_a] && !shadow_pending[held_sel.reg_b];

			check_value({row_name[i], " op_valid"}, 32'(issued), 32'(op_valid));
			check_value({row_name[i], " busy"}, 32'(held && !issued), 32'(busy));
			if (issued) begin
				check_value({row_name[i], " sel"}, 32'(held_sel), 32'(operands.sel));
				check_value({row_name[i], " a_value"}, 32'(shadow_regs[held_sel.reg_a]),
					32'(operands.a_value));
				check_value({row_name[i], " b_value"}, 32'(shadow_regs[held_sel.reg_b]),
					32'(operands.b_value));
				if (held_sel.wr_sel != 7'd0)
					shadow_pending[held_sel.wr_sel] = 1'b1;
				held = 1'b0;
			end

			@(posedge CLK);	// op_valid must have dropped by this quiet cycle
			#1;
			check_value({row_name[i], " op_valid idle"}, 32'(1'b0), 32'(op_valid));
			check_value({row_name[i], " busy idle"}, 32'(held), 32'(busy));
		end

		if (held) begin
			fail_run("Table ended with an instruction still held");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== slurm16_cpu_pipeline_control.sv ====
`default_nettype none

module slurm16_cpu_pipeline_control (
	input  logic CLK,
	input  logic reset,
	input  logic instr_valid,
	input  logic [slurm16_pkg::BITS - 1:0] instruction,
	input  slurm16_pkg::reg_sel_t sel,
	input  logic conflict,
	input  logic [slurm16_pkg::BITS - 1:0] rd_a,
	input  logic [slurm16_pkg::BITS - 1:0] rd_b,
	output logic [slurm16_pkg::BITS - 1:0] held_instruction,
	output logic issue,
	output logic busy,
	output logic op_valid,
	output slurm16_pkg::operand_bundle_t operands
);

	slurm16_pkg::ctrl_state_t state;
	slurm16_pkg::ctrl_state_t next_state;
	logic [slurm16_pkg::BITS - 1:0] slot;	// instruction waiting on a pending register
	logic holding;
	logic accept;

	assign holding = (state == slurm16_pkg::CTRL_HOLD);
	assign accept = instr_valid && !holding;	// strobes during a hold are lost

	// the decoder looks at the incoming word while the slot is empty
	assign held_instruction = holding ? slot : instruction;

	assign issue = (holding || accept) && !conflict;

	// ####################
	// state machine
	// ####################

	always_comb begin
		next_state = state;
		case (state)
			slurm16_pkg::CTRL_IDLE, slurm16_pkg::CTRL_ISSUE: begin
				if (accept && conflict)
					next_state = slurm16_pkg::CTRL_HOLD;
				else if (accept)
					next_state = slurm16_pkg::CTRL_ISSUE;
				else
					next_state = slurm16_pkg::CTRL_IDLE;
			end
			slurm16_pkg::CTRL_HOLD: begin
				if (!conflict)
					next_state = slurm16_pkg::CTRL_ISSUE;	// last blocker retired
			end
			default: begin
				next_state = slurm16_pkg::CTRL_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= slurm16_pkg::CTRL_IDLE;
			busy <= 1'b0;
			op_valid <= 1'b0;
		end else begin
			state <= next_state;
			busy <= (next_state == slurm16_pkg::CTRL_HOLD);
			op_valid <= (next_state == slurm16_pkg::CTRL_ISSUE);	// one pulse per issued instruction
		end
	end

	// ####################
	// payload capture
	// ####################

	always_ff @(posedge CLK) begin
		if (accept)
			slot <= instruction;
		if (issue) begin
			operands.sel <= sel;
			operands.a_value <= rd_a;
			operands.b_value <= rd_b;
		end
	end

endmodule

`default_nettype wire

// ==== slurm16_cpu_registers.sv ====
`default_nettype none

module slurm16_cpu_registers (
	input  logic CLK,
	input  logic reset,
	input  logic wr_en,
	input  slurm16_pkg::writeback_t wr,
	input  logic [slurm16_pkg::REGISTER_BITS - 1:0] rd_a_sel,
	input  logic [slurm16_pkg::REGISTER_BITS - 1:0] rd_b_sel,
	output logic [slurm16_pkg::BITS - 1:0] rd_a,
	output logic [slurm16_pkg::BITS - 1:0] rd_b
);

	logic [slurm16_pkg::BITS - 1:0] regs [slurm16_pkg::NUM_REGISTERS];
	logic wr_live;

	assign wr_live = wr_en && (wr.sel != '0);	// r0 is hardwired to zero

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < slurm16_pkg::NUM_REGISTERS; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[wr.sel] <= wr.data;
		end
	end

	// ####################
	// read ports with write-through
	// ####################

	always_comb begin
		if (rd_a_sel == '0)
			rd_a = '0;
		else if (wr_live && (wr.sel == rd_a_sel))
			rd_a = wr.data;	// forward the value landing this cycle
		else
			rd_a = regs[rd_a_sel];
	end

	always_comb begin
		if (rd_b_sel == '0)
			rd_b = '0;
		else if (wr_live && (wr.sel == rd_b_sel))
			rd_b = wr.data;
		else
			rd_b = regs[rd_b_sel];
	end

endmodule

`default_nettype wire

// ==== slurm16_pkg.sv ====
`default_nettype none

package slurm16_pkg;

	// ####################
	// widths and special registers
	// ####################

	localparam int BITS = 16;	// instruction and data width
	localparam int REGISTER_BITS = 7;	// select width covers the extended registers
	localparam int NUM_REGISTERS = 128;
	localparam logic [REGISTER_BITS - 1:0] LINK_REGISTER = 7'd15;	// return address for ret
	localparam logic [REGISTER_BITS - 1:0] INTERRUPT_LINK_REGISTER = 7'd14;	// used by iret

	// ####################
	// enumerations
	// ####################

	typedef enum logic [3:0] {
		CLASS_NOP_RET = 4'd0,
		CLASS_ALU_REG_REG = 4'd1,
		CLASS_ALU_SINGLE_REG = 4'd2,
		CLASS_ALU_REG_IMM = 4'd3,
		CLASS_BRANCH = 4'd4,
		CLASS_COND_MOV = 4'd5,
		CLASS_LOAD = 4'd6,
		CLASS_PEEK = 4'd7,
		CLASS_ALU_REG_EXREG = 4'd8,
		CLASS_ALU_EXREG_REG = 4'd9,
		CLASS_LOAD_EX = 4'd10
	} instr_class_t;	// codes 11 to 15 decode as nothing

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_HOLD,
		CTRL_ISSUE
	} ctrl_state_t;

	// ####################
	// bundles
	// ####################

	typedef struct packed {
		logic [REGISTER_BITS - 1:0] reg_a;
		logic [REGISTER_BITS - 1:0] reg_b;
		logic [REGISTER_BITS - 1:0] wr_sel;	// zero means the instruction writes nothing
	} reg_sel_t;

	typedef struct packed {
		reg_sel_t sel;
		logic [BITS - 1:0] a_value;
		logic [BITS - 1:0] b_value;
	} operand_bundle_t;

	typedef struct packed {
		logic [REGISTER_BITS - 1:0] sel;
		logic [BITS - 1:0] data;
	} writeback_t;

	// ####################
	// instruction fields
	// ####################

	function automatic instr_class_t class_from_ins(input logic [BITS - 1:0] ins);
		return instr_class_t'(ins[15:12]);
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_dest_from_ins(input logic [BITS - 1:0] ins);
		return {3'b000, ins[7:4]};
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_src_from_ins(input logic [BITS - 1:0] ins);
		return {3'b000, ins[3:0]};
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_idx_from_ins(input logic [BITS - 1:0] ins);
		return {3'b000, ins[11:8]};
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_extended_from_ins(
		input logic [BITS - 1:0] ins
	);
		return ins[10:4];	// the full extended register number
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_branch_ind_from_ins(
		input logic [BITS - 1:0] ins
	);
		return {3'b000, ins[7:4]};
	endfunction

	function automatic logic is_iret(input logic [BITS - 1:0] ins);
		return ins[9];
	endfunction

	function automatic logic is_ret(input logic [BITS - 1:0] ins);
		return ins[8];
	endfunction

endpackage

`default_nettype wire

// ==== verilog.f ====
slurm16_pkg.sv
slurm16_cpu_decode.sv
slurm16_cpu_registers.sv
slurm16_cpu_hazard.sv
slurm16_cpu_pipeline_control.sv
slurm16_cpu_operand_fetch.sv
slurm16_cpu_operand_fetch_assert.sv
slurm16_cpu_operand_fetch_tb.sv
